// ==== hdl/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;
    localparam int ID_W   = 8;

    typedef logic [ADDR_W-1:0] t_addr;
    typedef logic [DATA_W-1:0] t_data;
    typedef logic [ID_W-1:0]   t_id;

    // Origin of a packet entering the memory pipe
    typedef enum logic {
        LOAD,
        FILL
    } t_arb_type;

    // Pipe packet, qualified by a separate valid
    typedef struct packed {
        t_arb_type arb_type;
        t_id       id;      // load tag or fill entry index
        t_addr     addr;
        t_data     data;    // FILL only
    } t_mempipe_arb;

    // Decision at mm5, also the load response code
    typedef enum logic [1:0] {
        NONE,
        HIT,
        MISS,
        RETRY
    } t_mempipe_action;

    // Fields captured when a fill entry is allocated
    typedef struct packed {
        t_addr paddr;
        t_id   alloc_id;
    } t_flq_static;

    typedef enum logic [1:0] {
        FREE,
        FETCH,
        FILL_REQ
    } t_flq_state;

    typedef enum logic [1:0] {
        APB_IDLE,
        APB_SETUP,
        APB_ACCESS
    } t_apb_state;

    typedef struct packed {
        logic  psel;
        logic  penable;
        logic  pwrite;
        t_addr paddr;
    } t_apb_req;

    typedef struct packed {
        logic  pready;
        t_data prdata;
    } t_apb_rsp;

endpackage

`default_nettype wire

// ==== hdl/pipe_arbiter.sv ====
`default_nettype none
`timescale 1ns/1ps

module pipe_arbiter #(
    parameter int  NREQS = 2,
    parameter type T     = logic
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic [NREQS-1:0] req_valids,
    input  wire T                 req_pkts [NREQS],
    input  wire logic             ext_gnt,
    output logic      [NREQS-1:0] gnts,
    output logic                  ext_req_valid,
    output T                      ext_req_pkt
);

    logic [NREQS-1:0] sel;

    // Lowest requesting index wins
    always_comb begin
        sel = '0;
        for (int i = 0; i < NREQS; i++) begin
            if (req_valids[i] && ~|sel) begin
                sel[i] = 1'b1;
            end
        end
    end

    always_comb begin
        ext_req_pkt = req_pkts[0];
        for (int i = 0; i < NREQS; i++) begin
            if (sel[i]) begin
                ext_req_pkt = req_pkts[i];
            end
        end
    end

    assign ext_req_valid = |req_valids;
    assign gnts          = ext_gnt ? sel : '0;

    a_gnt_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(gnts) && ((gnts & ~req_valids) == '0));

endmodule

`default_nettype wire

// ==== hdl/fillq_entry.sv ====
`default_nettype none
`timescale 1ns/1ps

module fillq_entry #(
    parameter int FLQ_ENTRIES = 4
) (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic [$clog2(FLQ_ENTRIES)-1:0] id,
    input  wire logic                           alloc,
    input  wire mem_pkg::t_flq_static           alloc_static,
    input  wire logic                           pipe_gnt,
    input  wire logic                           apb_gnt,
    input  wire logic                           fetch_done,
    input  wire mem_pkg::t_data                 fetch_data,
    input  wire logic                           pipe_valid_mm5,
    input  wire mem_pkg::t_mempipe_arb          pipe_req_pkt_mm5,
    output logic                                valid,
    output mem_pkg::t_flq_static                e_static,
    output logic                                pipe_req,
    output mem_pkg::t_mempipe_arb               pipe_req_pkt,
    output logic                                apb_req
);

    import mem_pkg::*;

    t_flq_state state;
    logic       issued;     // request of the current state accepted
    t_data      line_data;
    logic       own_fill_mm5;

    assign own_fill_mm5 = pipe_valid_mm5 && pipe_req_pkt_mm5.arb_type == FILL &&
                          pipe_req_pkt_mm5.id == ID_W'(id);

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= FREE;
            issued <= 1'b0;
        end else begin
            case (state)
                FREE: begin
                    if (alloc) begin
                        state <= FETCH;
                    end
                end
                FETCH: begin
                    if (apb_gnt) begin
                        issued <= 1'b1;
                    end
                    if (fetch_done) begin
                        state  <= FILL_REQ;
                        issued <= 1'b0;
                    end
                end
                FILL_REQ: begin
                    if (pipe_gnt) begin
                        issued <= 1'b1;
                    end
                    // Free once our fill has written the array
                    if (issued && own_fill_mm5) begin
                        state  <= FREE;
                        issued <= 1'b0;
                    end
                end
                default: begin
                    state <= FREE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            e_static <= alloc_static;
        end
        if (fetch_done && state == FETCH) begin
            line_data <= fetch_data;
        end
    end

    assign valid    = state != FREE;
    assign apb_req  = state == FETCH && !issued;
    assign pipe_req = state == FILL_REQ && !issued;

    always_comb begin
        pipe_req_pkt.arb_type = FILL;
        pipe_req_pkt.id       = ID_W'(id);
        pipe_req_pkt.addr     = e_static.paddr;
        pipe_req_pkt.data     = line_data;
    end

    a_alloc_free: assert property (@(posedge clk) disable iff (rst)
        alloc |-> state == FREE);

endmodule

`default_nettype wire

// ==== hdl/fillq.sv ====
`default_nettype none
`timescale 1ns/1ps

module fillq #(
    parameter int FLQ_ENTRIES = 4
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  flq_alloc_mm5,
    input  wire logic                  pipe_gnt_mm0,
    input  wire mem_pkg::t_mempipe_arb pipe_pkt_mm1,
    input  wire logic                  pipe_valid_mm5,
    input  wire mem_pkg::t_mempipe_arb pipe_req_pkt_mm5,
    input  wire logic                  fetch_gnt,
    input  wire logic                  fetch_done,
    input  wire mem_pkg::t_data        fetch_data,
    output logic                       pipe_req_mm0,
    output mem_pkg::t_mempipe_arb      pipe_req_pkt_mm0,
    output logic                       flq_addr_mat_mm2,
    output logic                       flq_full,
    output logic                       fetch_req,
    output mem_pkg::t_addr             fetch_pkt
);

    import mem_pkg::*;

    localparam int IDX_W = $clog2(FLQ_ENTRIES);

    logic [FLQ_ENTRIES-1:0] e_valid;
    logic [FLQ_ENTRIES-1:0] alloc_sel;
    logic [FLQ_ENTRIES-1:0] e_alloc;
    t_flq_static            alloc_static;
    t_flq_static            e_static [FLQ_ENTRIES];

    logic [FLQ_ENTRIES-1:0] e_pipe_req;
    logic [FLQ_ENTRIES-1:0] e_pipe_gnt;
    t_mempipe_arb           e_pipe_req_pkt [FLQ_ENTRIES];

    logic [FLQ_ENTRIES-1:0] e_apb_req;
    logic [FLQ_ENTRIES-1:0] e_apb_gnt;
    t_addr                  e_apb_pkt [FLQ_ENTRIES];
    logic [FLQ_ENTRIES-1:0] e_fetch_done;
    logic [IDX_W-1:0]       fetch_owner;

    logic [FLQ_ENTRIES-1:0] cam_mat_mm1;

    // Allocation goes to the first free entry
    always_comb begin
        alloc_sel = '0;
        for (int e = 0; e < FLQ_ENTRIES; e++) begin
            if (!e_valid[e] && ~|alloc_sel) begin
                alloc_sel[e] = 1'b1;
            end
        end
    end

    assign e_alloc               = flq_alloc_mm5 ? alloc_sel : '0;
    assign alloc_static.paddr    = pipe_req_pkt_mm5.addr;
    assign alloc_static.alloc_id = pipe_req_pkt_mm5.id;
    assign flq_full              = &e_valid;

    for (genvar e = 0; e < FLQ_ENTRIES; e++) begin : g_entries
        fillq_entry #(
            .FLQ_ENTRIES(FLQ_ENTRIES)
        ) entry (
            .clk,
            .rst,
            .id               (IDX_W'(e)),
            .alloc            (e_alloc[e]),
            .alloc_static,
            .pipe_gnt         (e_pipe_gnt[e]),
            .apb_gnt          (e_apb_gnt[e]),
            .fetch_done       (e_fetch_done[e]),
            .fetch_data,
            .pipe_valid_mm5,
            .pipe_req_pkt_mm5,
            .valid            (e_valid[e]),
            .e_static         (e_static[e]),
            .pipe_req         (e_pipe_req[e]),
            .pipe_req_pkt     (e_pipe_req_pkt[e]),
            .apb_req          (e_apb_req[e])
        );

        assign e_apb_pkt[e]    = e_static[e].paddr;
        assign e_fetch_done[e] = fetch_done && fetch_owner == IDX_W'(e);

        // Full line address match against pending entries
        assign cam_mat_mm1[e] = e_valid[e] && e_static[e].paddr == pipe_pkt_mm1.addr;

        a_alloc_unique: assert property (@(posedge clk) disable iff (rst)
            flq_alloc_mm5 && e_valid[e] |-> alloc_static.paddr != e_static[e].paddr);
    end

    always_ff @(posedge clk) begin
        flq_addr_mat_mm2 <= |cam_mat_mm1;
    end

    pipe_arbiter #(
        .NREQS(FLQ_ENTRIES),
        .T    (t_mempipe_arb)
    ) pipe_arb (
        .clk,
        .rst,
        .req_valids   (e_pipe_req),
        .req_pkts     (e_pipe_req_pkt),
        .ext_gnt      (pipe_gnt_mm0),
        .gnts         (e_pipe_gnt),
        .ext_req_valid(pipe_req_mm0),
        .ext_req_pkt  (pipe_req_pkt_mm0)
    );

    pipe_arbiter #(
        .NREQS(FLQ_ENTRIES),
        .T    (t_addr)
    ) apb_arb (
        .clk,
        .rst,
        .req_valids   (e_apb_req),
        .req_pkts     (e_apb_pkt),
        .ext_gnt      (fetch_gnt),
        .gnts         (e_apb_gnt),
        .ext_req_valid(fetch_req),
        .ext_req_pkt  (fetch_pkt)
    );

    // Only one fetch is outstanding, so one owner register routes fetch_done
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_owner <= '0;
        end else if (fetch_gnt) begin
            for (int e = 0; e < FLQ_ENTRIES; e++) begin
                if (e_apb_gnt[e]) begin
                    fetch_owner <= IDX_W'(e);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/apb_fill_master.sv ====
`default_nettype none
`timescale 1ns/1ps

module apb_fill_master (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             fetch_req,
    input  wire mem_pkg::t_addr   fetch_pkt,
    input  wire mem_pkg::t_apb_rsp apb_rsp,
    output logic                  fetch_gnt,
    output logic                  fetch_done,
    output mem_pkg::t_data        fetch_data,
    output mem_pkg::t_apb_req     apb_req
);

    import mem_pkg::*;

    t_apb_state state;
    t_addr      paddr_q;

    // Accept a new fetch only when the bus is idle
    assign fetch_gnt = state == APB_IDLE && fetch_req;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= APB_IDLE;
        end else begin
            case (state)
                APB_IDLE: begin
                    if (fetch_gnt) begin
                        state <= APB_SETUP;
                    end
                end
                APB_SETUP: begin
                    state <= APB_ACCESS;
                end
                APB_ACCESS: begin
                    if (apb_rsp.pready) begin
                        state <= APB_IDLE;
                    end
                end
                default: begin
                    state <= APB_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_gnt) begin
            paddr_q <= fetch_pkt;
        end
    end

    assign fetch_done = state == APB_ACCESS && apb_rsp.pready;
    assign fetch_data = apb_rsp.prdata;

    always_comb begin
        apb_req.psel    = state != APB_IDLE;
        apb_req.penable = state == APB_ACCESS;
        apb_req.pwrite  = 1'b0;
        apb_req.paddr   = paddr_q;
    end

    // Access phase needs a setup cycle first
    a_penable_after_setup: assert property (@(posedge clk) disable iff (rst)
        $rose(apb_req.penable) |-> $past(apb_req.psel) && !$past(apb_req.penable));

endmodule

`default_nettype wire

// ==== hdl/mem_pipe.sv ====
`default_nettype none
`timescale 1ns/1ps

module mem_pipe #(
    parameter int NUM_SETS = 16
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  load_req,
    input  wire mem_pkg::t_mempipe_arb load_req_pkt,
    input  wire logic                  flq_req,
    input  wire mem_pkg::t_mempipe_arb flq_req_pkt,
    input  wire logic                  flq_addr_mat_mm2,
    input  wire logic                  flq_full,
    output logic                       load_gnt,
    output logic                       flq_gnt,
    output mem_pkg::t_mempipe_arb      pipe_pkt_mm1,
    output logic                       pipe_valid_mm5,
    output mem_pkg::t_mempipe_arb      pipe_req_pkt_mm5,
    output mem_pkg::t_mempipe_action   pipe_action_mm5,
    output logic                       flq_alloc_mm5,
    output logic                       load_resp_valid,
    output mem_pkg::t_id               load_resp_id,
    output mem_pkg::t_mempipe_action   load_resp_action,
    output mem_pkg::t_data             load_resp_data
);

    import mem_pkg::*;

    localparam int SET_W = $clog2(NUM_SETS);
    localparam int TAG_W = ADDR_W - 2 - SET_W;

    logic [1:0]          arb_valids;
    t_mempipe_arb        arb_pkts [2];
    logic [1:0]          arb_gnts;
    logic                valid_mm0;
    t_mempipe_arb        pkt_mm0;
    logic [5:1]          valid_q;
    t_mempipe_arb        pkt_q [1:5];

    logic [NUM_SETS-1:0] arr_valid;
    logic [TAG_W-1:0]    arr_tag [NUM_SETS];
    t_data               arr_data [NUM_SETS];
    logic [SET_W-1:0]    set_mm1;
    logic [SET_W-1:0]    set_mm5;
    logic [5:2]          hit_q;
    t_data               data_q [2:5];
    logic [5:3]          mat_q;

    logic [3:0]          hist_valid;
    t_addr               hist_addr [4];
    logic                hist_mat_mm5;
    logic                fill_mm5;
    t_mempipe_action     action_mm5;

    // Fill queue at index 0 always beats the load port
    assign arb_valids  = {load_req, flq_req};
    assign arb_pkts[0] = flq_req_pkt;
    assign arb_pkts[1] = load_req_pkt;

    pipe_arbiter #(
        .NREQS(2),
        .T    (t_mempipe_arb)
    ) pipe_arb (
        .clk,
        .rst,
        .req_valids   (arb_valids),
        .req_pkts     (arb_pkts),
        .ext_gnt      (1'b1),
        .gnts         (arb_gnts),
        .ext_req_valid(valid_mm0),
        .ext_req_pkt  (pkt_mm0)
    );

    assign flq_gnt  = arb_gnts[0];
    assign load_gnt = arb_gnts[1];

    // Pipe never stalls
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[4:1], valid_mm0};
        end
    end

    always_ff @(posedge clk) begin
        pkt_q[1] <= pkt_mm0;
        for (int s = 2; s <= 5; s++) begin
            pkt_q[s] <= pkt_q[s-1];
        end
    end

    assign pipe_pkt_mm1 = pkt_q[1];
    assign set_mm1      = pkt_q[1].addr[2 +: SET_W];

    // Array lookup at mm1, result carried down to mm5
    always_ff @(posedge clk) begin
        hit_q[2]   <= arr_valid[set_mm1] &&
                      arr_tag[set_mm1] == pkt_q[1].addr[ADDR_W-1 -: TAG_W];
        data_q[2]  <= arr_data[set_mm1];
        hit_q[5:3] <= hit_q[4:2];
        for (int s = 3; s <= 5; s++) begin
            data_q[s] <= data_q[s-1];
        end
        mat_q <= {mat_q[4:3], flq_addr_mat_mm2};
    end

    assign fill_mm5 = valid_q[5] && pkt_q[5].arb_type == FILL;
    assign set_mm5  = pkt_q[5].addr[2 +: SET_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            arr_valid <= '0;
        end else if (fill_mm5) begin
            arr_valid[set_mm5] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_mm5) begin
            arr_tag[set_mm5]  <= pkt_q[5].addr[ADDR_W-1 -: TAG_W];
            arr_data[set_mm5] <= pkt_q[5].data;
        end
    end

    // Allocations too recent for the fill queue CAM to have seen
    always_ff @(posedge clk) begin
        if (rst) begin
            hist_valid <= '0;
        end else begin
            hist_valid <= {hist_valid[2:0], flq_alloc_mm5};
        end
    end

    always_ff @(posedge clk) begin
        hist_addr[0] <= pkt_q[5].addr;
        for (int i = 1; i < 4; i++) begin
            hist_addr[i] <= hist_addr[i-1];
        end
    end

    always_comb begin
        hist_mat_mm5 = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (hist_valid[i] && hist_addr[i] == pkt_q[5].addr) begin
                hist_mat_mm5 = 1'b1;
            end
        end
    end

    always_comb begin
        action_mm5 = NONE;
        if (valid_q[5] && pkt_q[5].arb_type == LOAD) begin
            if (hit_q[5]) begin
                action_mm5 = HIT;
            end else if (mat_q[5] || hist_mat_mm5 || flq_full) begin
                action_mm5 = RETRY;
            end else begin
                action_mm5 = MISS;
            end
        end
    end

    assign pipe_valid_mm5   = valid_q[5];
    assign pipe_req_pkt_mm5 = pkt_q[5];
    assign pipe_action_mm5  = action_mm5;
    assign flq_alloc_mm5    = action_mm5 == MISS;

    assign load_resp_valid  = valid_q[5] && pkt_q[5].arb_type == LOAD;
    assign load_resp_id     = pkt_q[5].id;
    assign load_resp_action = action_mm5;
    assign load_resp_data   = data_q[5];

    a_resp_latency: assert property (@(posedge clk) disable iff (rst)
        load_gnt |-> ##5 (load_resp_valid && load_resp_id == $past(load_req_pkt.id, 5)));

endmodule

`default_nettype wire

// ==== hdl/mem_subsys_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module mem_subsys_top #(
    parameter int FLQ_ENTRIES = 4,
    parameter int NUM_SETS    = 16
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  load_req,
    input  wire mem_pkg::t_mempipe_arb load_req_pkt,
    input  wire mem_pkg::t_apb_rsp     apb_rsp,
    output logic                       load_gnt,
    output logic                       load_resp_valid,
    output mem_pkg::t_id               load_resp_id,
    output mem_pkg::t_mempipe_action   load_resp_action,
    output mem_pkg::t_data             load_resp_data,
    output mem_pkg::t_apb_req          apb_req
);

    import mem_pkg::*;

    logic         flq_req;
    t_mempipe_arb flq_req_pkt;
    logic         flq_gnt;
    t_mempipe_arb pipe_pkt_mm1;
    logic         flq_addr_mat_mm2;
    logic         flq_full;
    logic         pipe_valid_mm5;
    t_mempipe_arb pipe_req_pkt_mm5;
    logic         flq_alloc_mm5;
    logic         fetch_req;
    t_addr        fetch_pkt;
    logic         fetch_gnt;
    logic         fetch_done;
    t_data        fetch_data;

    mem_pipe #(
        .NUM_SETS(NUM_SETS)
    ) mem_pipe_i (
        .clk,
        .rst,
        .load_req,
        .load_req_pkt,
        .flq_req,
        .flq_req_pkt,
        .flq_addr_mat_mm2,
        .flq_full,
        .load_gnt,
        .flq_gnt,
        .pipe_pkt_mm1,
        .pipe_valid_mm5,
        .pipe_req_pkt_mm5,
        .pipe_action_mm5 (),
        .flq_alloc_mm5,
        .load_resp_valid,
        .load_resp_id,
        .load_resp_action,
        .load_resp_data
    );

    fillq #(
        .FLQ_ENTRIES(FLQ_ENTRIES)
    ) fillq_i (
        .clk,
        .rst,
        .flq_alloc_mm5,
        .pipe_gnt_mm0    (flq_gnt),
        .pipe_pkt_mm1,
        .pipe_valid_mm5,
        .pipe_req_pkt_mm5,
        .fetch_gnt,
        .fetch_done,
        .fetch_data,
        .pipe_req_mm0    (flq_req),
        .pipe_req_pkt_mm0(flq_req_pkt),
        .flq_addr_mat_mm2,
        .flq_full,
        .fetch_req,
        .fetch_pkt
    );

    apb_fill_master apb_fill_master_i (
        .clk,
        .rst,
        .fetch_req,
        .fetch_pkt,
        .apb_rsp,
        .fetch_gnt,
        .fetch_done,
        .fetch_data,
        .apb_req
    );

endmodule

`default_nettype wire

// ==== verif/apb_mem_model.sv ====
`default_nettype none
`timescale 1ns/1ps

module apb_mem_model (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire mem_pkg::t_apb_req apb_req,
    output mem_pkg::t_apb_rsp      apb_rsp
);

    import mem_pkg::*;

    localparam int NUM_WORDS = 2**(ADDR_W-2);

    integer     seed = 95;
    logic [1:0] wait_cnt;
    // Completed transfers per word address
    int         xfer_cnt [NUM_WORDS];

    // Wait states drawn in the setup cycle, counted down during access
    always @(posedge clk) begin
        if (rst) begin
            wait_cnt <= '0;
        end else if (apb_req.psel && !apb_req.penable) begin
            wait_cnt <= 2'($random(seed));
        end else if (apb_req.penable && wait_cnt != 2'd0) begin
            wait_cnt <= wait_cnt - 2'd1;
        end
    end

    always @(posedge clk) begin
        if (!rst && apb_req.psel && apb_req.penable && apb_rsp.pready) begin
            xfer_cnt[apb_req.paddr[ADDR_W-1:2]] <= xfer_cnt[apb_req.paddr[ADDR_W-1:2]] + 1;
        end
    end

    assign apb_rsp.pready = apb_req.psel && apb_req.penable && wait_cnt == 2'd0;
    assign apb_rsp.prdata = DATA_W'(apb_req.paddr) ^ 32'hA5A5_0000;

endmodule

`default_nettype wire

// ==== verif/mem_subsys_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module mem_subsys_tb;

    import mem_pkg::*;

    localparam int    FLQ_ENTRIES = 4;
    localparam int    NUM_SETS    = 16;
    localparam int    LINE_W      = ADDR_W - 2;
    // Single loads plus hit loops in the sequence below
    localparam int    LOAD_OPS    = 22;
    localparam int    MAX_CYCLES  = LOAD_OPS * 200;
    localparam t_data XOR_PAT     = 32'hA5A5_0000;

    // One line per set, so no fill evicts another
    localparam t_addr LINES [8] = '{16'h1000, 16'h2004, 16'h3008, 16'h400C,
                                    16'h5010, 16'h6014, 16'h7018, 16'h801C};

    logic            clk;
    logic            rst;
    logic            load_req;
    t_mempipe_arb    load_req_pkt;
    logic            load_gnt;
    logic            load_resp_valid;
    t_id             load_resp_id;
    t_mempipe_action load_resp_action;
    t_data           load_resp_data;
    t_apb_req        apb_req;
    t_apb_rsp        apb_rsp;

    logic [4:0]      gnt_sh;
    t_id             id_sh [5];
    t_addr           addr_sh [5];
    t_data           exp_data;
    t_addr           paddr_q;
    bit              resp_seen [256];
    t_mempipe_action resp_action [256];
    bit              missed [2**LINE_W];
    int              next_id = 0;

    mem_subsys_top #(
        .FLQ_ENTRIES(FLQ_ENTRIES),
        .NUM_SETS   (NUM_SETS)
    ) mem_subsys_top_i (
        .clk,
        .rst,
        .load_req,
        .load_req_pkt,
        .apb_rsp,
        .load_gnt,
        .load_resp_valid,
        .load_resp_id,
        .load_resp_action,
        .load_resp_data,
        .apb_req
    );

    apb_mem_model mem_i (
        .clk,
        .rst,
        .apb_req,
        .apb_rsp
    );

    always #4 clk = ~clk;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    // Grant history, so a response can be matched to its load
    always @(posedge clk) begin
        if (rst) begin
            gnt_sh <= '0;
        end else begin
            gnt_sh <= {gnt_sh[3:0], load_gnt};
        end
        id_sh[0]   <= load_req_pkt.id;
        addr_sh[0] <= load_req_pkt.addr;
        for (int s = 1; s < 5; s++) begin
            id_sh[s]   <= id_sh[s-1];
            addr_sh[s] <= addr_sh[s-1];
        end
        paddr_q <= apb_req.paddr;
    end

    assign exp_data = DATA_W'(addr_sh[4]) ^ XOR_PAT;

    always @(posedge clk) begin
        if (!rst && load_resp_valid) begin
            resp_seen[load_resp_id]   <= 1'b1;
            resp_action[load_resp_id] <= load_resp_action;
            if (load_resp_action == MISS) begin
                missed[addr_sh[4][ADDR_W-1:2]] <= 1'b1;
            end
        end
    end

    a_reset_quiet: assert property (@(posedge clk)
        $past(rst) |-> !load_gnt && !load_resp_valid && !apb_req.psel && !apb_req.penable)
    else report_failure($sformatf(
        "** Error: load_gnt=%h load_resp_valid=%h psel=%h penable=%h, expected 0",
        $sampled(load_gnt), $sampled(load_resp_valid), $sampled(apb_req.psel),
        $sampled(apb_req.penable)));

    a_resp_after_gnt: assert property (@(posedge clk) disable iff (rst)
        gnt_sh[4] |-> load_resp_valid && load_resp_id == id_sh[4])
    else report_failure($sformatf(
        "** Error: load_resp_valid=%h load_resp_id=%h, expected 1 and %h",
        $sampled(load_resp_valid), $sampled(load_resp_id), $sampled(id_sh[4])));

    a_resp_granted: assert property (@(posedge clk) disable iff (rst)
        load_resp_valid |-> gnt_sh[4])
    else report_failure("Load response without a load granted 5 cycles earlier");

    a_hit_data: assert property (@(posedge clk) disable iff (rst)
        load_resp_valid && load_resp_action == HIT |-> load_resp_data == exp_data)
    else report_failure($sformatf("** Error: load_resp_data = %h, expected %h",
        $sampled(load_resp_data), $sampled(exp_data)));

    a_hit_fetched: assert property (@(posedge clk) disable iff (rst)
        load_resp_valid && load_resp_action == HIT |->
        mem_i.xfer_cnt[addr_sh[4][ADDR_W-1:2]] != 0)
    else report_failure($sformatf("HIT on line %h that was never fetched",
        $sampled(addr_sh[4])));

    // A line that already missed is pending or cached
    a_no_second_miss: assert property (@(posedge clk) disable iff (rst)
        load_resp_valid && load_resp_action == MISS |-> !missed[addr_sh[4][ADDR_W-1:2]])
    else report_failure($sformatf("Second MISS on line %h", $sampled(addr_sh[4])));

    a_one_fetch_per_line: assert property (@(posedge clk) disable iff (rst)
        apb_req.psel && apb_req.penable && apb_rsp.pready |->
        mem_i.xfer_cnt[apb_req.paddr[ADDR_W-1:2]] == 0)
    else report_failure($sformatf("Second APB transfer to line %h",
        $sampled(apb_req.paddr)));

    a_setup_first: assert property (@(posedge clk) disable iff (rst)
        $rose(apb_req.penable) |-> $past(apb_req.psel) && !$past(apb_req.penable))
    else report_failure("APB penable raised without a setup cycle");

    a_enable_with_sel: assert property (@(posedge clk) disable iff (rst)
        apb_req.penable |-> apb_req.psel)
    else report_failure("APB penable high while psel is low");

    // Fills only ever read memory
    a_read_only: assert property (@(posedge clk) disable iff (rst)
        apb_req.psel |-> !apb_req.pwrite)
    else report_failure($sformatf("** Error: pwrite = %h, expected 0",
        $sampled(apb_req.pwrite)));

    a_paddr_stable: assert property (@(posedge clk) disable iff (rst)
        apb_req.psel && !(apb_req.penable && apb_rsp.pready) |=> apb_req.paddr == paddr_q)
    else report_failure($sformatf("** Error: paddr = %h, expected %h",
        $sampled(apb_req.paddr), $sampled(paddr_q)));

    // Holds the request until the grant edge
    task automatic issue_load(input t_addr addr, output int id);
        @(negedge clk);
        assert (next_id < 256)
        else report_failure("Ran out of load ids");
        load_req              = 1'b1;
        load_req_pkt.arb_type = LOAD;
        load_req_pkt.id       = t_id'(next_id);
        load_req_pkt.addr     = addr;
        load_req_pkt.data     = '0;
        id                    = next_id;
        next_id++;
        @(posedge clk);
        while (!load_gnt) begin
            @(posedge clk);
        end
    endtask

    task automatic release_port();
        @(negedge clk);
        load_req     = 1'b0;
        load_req_pkt = '0;
    endtask

    task automatic wait_resp(input int id, output t_mempipe_action act);
        while (!resp_seen[id]) begin
            @(negedge clk);
        end
        act = resp_action[id];
    endtask

    task automatic check_action(input t_addr addr, input t_mempipe_action act,
                                input t_mempipe_action exp);
        assert (act == exp)
        else report_failure($sformatf(
            "** Error: load_resp_action for addr %h = %h, expected %h", addr, act, exp));
    endtask

    task automatic load_until_hit(input t_addr addr);
        int              id;
        t_mempipe_action act;

        act = NONE;
        while (act != HIT) begin
            issue_load(addr, id);
            release_port();
            wait_resp(id, act);
        end
    endtask

    initial begin
        int              id;
        int              burst_ids [FLQ_ENTRIES+1];
        t_mempipe_action act;

        clk          = 1'b0;
        rst          = 1'b1;
        load_req     = 1'b0;
        load_req_pkt = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // First touch misses, reloads retry until the fill lands
        issue_load(LINES[0], id);
        release_port();
        wait_resp(id, act);
        check_action(LINES[0], act, MISS);
        load_until_hit(LINES[0]);
        load_until_hit(LINES[1]);
        load_until_hit(LINES[2]);

        // One more miss than there are entries, back to back
        for (int i = 0; i <= FLQ_ENTRIES; i++) begin
            issue_load(LINES[3+i], burst_ids[i]);
        end
        release_port();
        for (int i = 0; i <= FLQ_ENTRIES; i++) begin
            wait_resp(burst_ids[i], act);
            check_action(LINES[3+i], act, i < FLQ_ENTRIES ? MISS : RETRY);
        end
        for (int i = 3; i < 8; i++) begin
            load_until_hit(LINES[i]);
        end

        // Every line should now be resident
        for (int i = 0; i < 8; i++) begin
            issue_load(LINES[i], id);
            release_port();
            wait_resp(id, act);
            check_action(LINES[i], act, HIT);
        end
        repeat (8) @(negedge clk);
        $display("NO ERRORS");
        $finish;
    end

    initial begin
        repeat (MAX_CYCLES) @(posedge clk);
        report_failure($sformatf("Timeout: load sequence still running after %0d cycles",
                                 MAX_CYCLES));
    end

endmodule

`default_nettype wire

// ==== sim.f ====
hdl/mem_pkg.sv
hdl/pipe_arbiter.sv
hdl/fillq_entry.sv
hdl/fillq.sv
hdl/apb_fill_master.sv
hdl/mem_pipe.sv
hdl/mem_subsys_top.sv
verif/apb_mem_model.sv
verif/mem_subsys_tb.sv

// ==== Bender.yml ====
package:
  name: mem_subsys

sources:
  - hdl/mem_pkg.sv
  - hdl/pipe_arbiter.sv
  - hdl/fillq_entry.sv
  - hdl/fillq.sv
  - hdl/apb_fill_master.sv
  - hdl/mem_pipe.sv
  - hdl/mem_subsys_top.sv
  - target: test
    files:
      - verif/apb_mem_model.sv
      - verif/mem_subsys_tb.sv
